/* branch_unit.sv */
module branch_unit (
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] inst,
    input  id_pkg::br_kind_e        br_kind,
    input  logic [id_pkg::xlen-1:0] rs_data,
    input  logic [id_pkg::xlen-1:0] rt_data,
    output id_pkg::br_t             br
);

    logic [id_pkg::xlen-1:0] pc_plus_4;
    logic [id_pkg::xlen-1:0] branch_target;
    logic [id_pkg::xlen-1:0] jump_target;
    logic                    rs_eq_rt;
    logic                    rs_neg;
    logic                    rs_zero;

    assign pc_plus_4     = pc + 32'd4;
    assign branch_target = pc_plus_4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    // stays in the current 256 MB region
    assign jump_target   = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_eq_rt = (rs_data == rt_data);
    assign rs_neg   = rs_data[31];
    assign rs_zero  = (rs_data == '0);

    always_comb begin
        br.taken  = 1'b0;
        br.target = branch_target;
        case (br_kind)
            id_pkg::br_beq:  br.taken = rs_eq_rt;
            id_pkg::br_bne:  br.taken = !rs_eq_rt;
            id_pkg::br_bgez: br.taken = !rs_neg;
            id_pkg::br_bltz: br.taken = rs_neg;
            id_pkg::br_bgtz: br.taken = !rs_neg && !rs_zero;
            id_pkg::br_blez: br.taken = rs_neg || rs_zero;
            id_pkg::br_j, id_pkg::br_jal: begin
                br.taken  = 1'b1;
                br.target = jump_target;
            end
            id_pkg::br_jr, id_pkg::br_jalr: begin
                br.taken  = 1'b1;
                br.target = rs_data;
            end
            default: begin
                br.taken  = 1'b0;
                br.target = '0;
            end
        endcase
    end

endmodule

/* id_pkg.sv */
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special group, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_jr   = 6'h08,
        fn_jalr = 6'h09,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    // regimm group, rt field
    typedef enum logic [4:0] {
        ri_bltz = 5'h00,
        ri_bgez = 5'h01
    } regimm_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs, src1_pc, src1_sa
    } src1_e;

    typedef enum logic [1:0] {
        src2_rt, src2_simm, src2_eight, src2_zimm
    } src2_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bltz, br_bgtz,
        br_blez, br_j, br_jal, br_jr, br_jalr
    } br_kind_e;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic if_stop;
        logic id_stop;
    } stall_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        alu_op_e               alu_op;
        src1_e                 src1;
        src2_e                 src2;
        logic                  mem_read;
        logic                  mem_write;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        br_kind_e              br_kind;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        alu_op_e               alu_op;
        src1_e                 src1;
        src2_e                 src2;
        logic                  mem_read;
        logic                  mem_write;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rs_data;
        logic [xlen-1:0]       rt_data;
    } id_ex_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

/* id_stage.f */
id_pkg.sv
if_id_reg.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
tb_id_stage_assertions.sv
tb_id_stage.sv

/* id_stage.sv */
module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  id_pkg::stall_t      stall,
    input  id_pkg::if_id_t      if_id,
    input  id_pkg::rf_write_t   ex_fwd,
    input  id_pkg::rf_write_t   mem_fwd,
    input  logic                ex_ram_read,
    input  id_pkg::rf_write_t   wb,
    output id_pkg::id_ex_t      id_ex,
    output id_pkg::br_t         br,
    output logic                stall_for_load
);

    id_pkg::if_id_t          held;
    id_pkg::ctrl_t           ctrl;
    logic [id_pkg::xlen-1:0] rf_rs_data;
    logic [id_pkg::xlen-1:0] rf_rt_data;
    logic [id_pkg::xlen-1:0] rs_data;
    logic [id_pkg::xlen-1:0] rt_data;

    if_id_reg u_if_id_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .stall     (stall),
        .if_id_in  (if_id),
        .if_id_out (held)
    );

    inst_decoder u_inst_decoder (
        .inst  (held.inst),
        .valid (held.valid),
        .ctrl  (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (ctrl.rs),
        .raddr2 (ctrl.rt),
        .rdata1 (rf_rs_data),
        .rdata2 (rf_rt_data),
        .wb     (wb)
    );

    operand_forward u_operand_forward (
        .rs             (ctrl.rs),
        .rt             (ctrl.rt),
        .rf_rs_data     (rf_rs_data),
        .rf_rt_data     (rf_rt_data),
        .ex_fwd         (ex_fwd),
        .mem_fwd        (mem_fwd),
        .ex_ram_read    (ex_ram_read),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .stall_for_load (stall_for_load)
    );

    branch_unit u_branch_unit (
        .pc      (held.pc),
        .inst    (held.inst),
        .br_kind (ctrl.br_kind),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .br      (br)
    );

    always_comb begin
        id_ex.valid     = held.valid;
        id_ex.pc        = held.pc;
        id_ex.inst      = held.inst;
        id_ex.alu_op    = ctrl.alu_op;
        id_ex.src1      = ctrl.src1;
        id_ex.src2      = ctrl.src2;
        id_ex.mem_read  = ctrl.mem_read;
        id_ex.mem_write = ctrl.mem_write;
        id_ex.rf_we     = ctrl.rf_we;
        id_ex.rf_waddr  = ctrl.rf_waddr;
        id_ex.rs_data   = rs_data;
        id_ex.rt_data   = rt_data;
    end

endmodule

/* if_id_reg.sv */
module if_id_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  id_pkg::stall_t stall,
    input  id_pkg::if_id_t if_id_in,
    output id_pkg::if_id_t if_id_out
);

    id_pkg::if_id_t entry_q;
    logic           insert_bubble;

    // fetch stopped while decode moves on
    assign insert_bubble = stall.if_stop && !stall.id_stop;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry_q <= '0;
        end else if (insert_bubble) begin
            entry_q <= '0;
        end else if (!stall.if_stop) begin
            entry_q <= if_id_in;
        end
        // both stops high: hold
    end

    assign if_id_out = entry_q;

endmodule

/* inst_decoder.sv */
module inst_decoder (
    input  logic [id_pkg::xlen-1:0] inst,
    input  logic                    valid,
    output id_pkg::ctrl_t           ctrl
);

    id_pkg::opcode_e                opcode;
    id_pkg::funct_e                 funct;
    id_pkg::regimm_e                regimm;
    logic [id_pkg::reg_addr_w-1:0]  rs;
    logic [id_pkg::reg_addr_w-1:0]  rt;
    logic [id_pkg::reg_addr_w-1:0]  rd;
    logic                           known;

    assign opcode = id_pkg::opcode_e'(inst[31:26]);
    assign funct  = id_pkg::funct_e'(inst[5:0]);
    assign regimm = id_pkg::regimm_e'(inst[20:16]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    always_comb begin
        known          = 1'b1;
        ctrl.alu_op    = id_pkg::alu_add;
        ctrl.src1      = id_pkg::src1_rs;
        ctrl.src2      = id_pkg::src2_rt;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.rf_we     = 1'b0;
        ctrl.rf_waddr  = '0;
        ctrl.br_kind   = id_pkg::br_none;
        ctrl.rs        = rs;
        ctrl.rt        = rt;

        case (opcode)
            id_pkg::op_special: begin
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rd;
                case (funct)
                    id_pkg::fn_addu: ctrl.alu_op = id_pkg::alu_add;
                    id_pkg::fn_subu: ctrl.alu_op = id_pkg::alu_sub;
                    id_pkg::fn_slt:  ctrl.alu_op = id_pkg::alu_slt;
                    id_pkg::fn_sltu: ctrl.alu_op = id_pkg::alu_sltu;
                    id_pkg::fn_and:  ctrl.alu_op = id_pkg::alu_and;
                    id_pkg::fn_or:   ctrl.alu_op = id_pkg::alu_or;
                    id_pkg::fn_xor:  ctrl.alu_op = id_pkg::alu_xor;
                    id_pkg::fn_nor:  ctrl.alu_op = id_pkg::alu_nor;
                    id_pkg::fn_sllv: ctrl.alu_op = id_pkg::alu_sll;
                    id_pkg::fn_srlv: ctrl.alu_op = id_pkg::alu_srl;
                    id_pkg::fn_srav: ctrl.alu_op = id_pkg::alu_sra;
                    // shift by the sa field
                    id_pkg::fn_sll: begin
                        ctrl.alu_op = id_pkg::alu_sll;
                        ctrl.src1   = id_pkg::src1_sa;
                    end
                    id_pkg::fn_srl: begin
                        ctrl.alu_op = id_pkg::alu_srl;
                        ctrl.src1   = id_pkg::src1_sa;
                    end
                    id_pkg::fn_sra: begin
                        ctrl.alu_op = id_pkg::alu_sra;
                        ctrl.src1   = id_pkg::src1_sa;
                    end
                    id_pkg::fn_jr: begin
                        ctrl.rf_we   = 1'b0;
                        ctrl.br_kind = id_pkg::br_jr;
                    end
                    // link value is pc + 8
                    id_pkg::fn_jalr: begin
                        ctrl.src1     = id_pkg::src1_pc;
                        ctrl.src2     = id_pkg::src2_eight;
                        ctrl.rf_waddr = 5'd31;
                        ctrl.br_kind  = id_pkg::br_jalr;
                    end
                    default: known = 1'b0;
                endcase
            end
            id_pkg::op_regimm: begin
                case (regimm)
                    id_pkg::ri_bltz: ctrl.br_kind = id_pkg::br_bltz;
                    id_pkg::ri_bgez: ctrl.br_kind = id_pkg::br_bgez;
                    default:         known = 1'b0;
                endcase
            end
            id_pkg::op_j:    ctrl.br_kind = id_pkg::br_j;
            id_pkg::op_jal: begin
                ctrl.src1     = id_pkg::src1_pc;
                ctrl.src2     = id_pkg::src2_eight;
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = 5'd31;
                ctrl.br_kind  = id_pkg::br_jal;
            end
            id_pkg::op_beq:  ctrl.br_kind = id_pkg::br_beq;
            id_pkg::op_bne:  ctrl.br_kind = id_pkg::br_bne;
            id_pkg::op_blez: ctrl.br_kind = id_pkg::br_blez;
            id_pkg::op_bgtz: ctrl.br_kind = id_pkg::br_bgtz;
            id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu, id_pkg::op_lui,
            id_pkg::op_andi, id_pkg::op_ori, id_pkg::op_xori, id_pkg::op_lw: begin
                ctrl.rf_we    = 1'b1;
                ctrl.rf_waddr = rt;
                ctrl.src2     = id_pkg::src2_simm;
                ctrl.mem_read = (opcode == id_pkg::op_lw);
                case (opcode)
                    id_pkg::op_slti:  ctrl.alu_op = id_pkg::alu_slt;
                    id_pkg::op_sltiu: ctrl.alu_op = id_pkg::alu_sltu;
                    id_pkg::op_lui:   ctrl.alu_op = id_pkg::alu_lui;
                    id_pkg::op_andi:  ctrl.alu_op = id_pkg::alu_and;
                    id_pkg::op_ori:   ctrl.alu_op = id_pkg::alu_or;
                    id_pkg::op_xori:  ctrl.alu_op = id_pkg::alu_xor;
                    default:          ctrl.alu_op = id_pkg::alu_add;
                endcase
                // logic immediates are zero extended
                if (opcode inside {id_pkg::op_andi, id_pkg::op_ori, id_pkg::op_xori}) begin
                    ctrl.src2 = id_pkg::src2_zimm;
                end
            end
            id_pkg::op_sw: begin
                ctrl.src2      = id_pkg::src2_simm;
                ctrl.mem_write = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // bubbles and unknown words become no-ops
        if (!valid || !known) begin
            ctrl.rf_we     = 1'b0;
            ctrl.rf_waddr  = '0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.br_kind   = id_pkg::br_none;
        end
    end

endmodule

/* operand_forward.sv */
module operand_forward (
    input  logic [id_pkg::reg_addr_w-1:0] rs,
    input  logic [id_pkg::reg_addr_w-1:0] rt,
    input  logic [id_pkg::xlen-1:0]       rf_rs_data,
    input  logic [id_pkg::xlen-1:0]       rf_rt_data,
    input  id_pkg::rf_write_t             ex_fwd,
    input  id_pkg::rf_write_t             mem_fwd,
    input  logic                          ex_ram_read,
    output logic [id_pkg::xlen-1:0]       rs_data,
    output logic [id_pkg::xlen-1:0]       rt_data,
    output logic                          stall_for_load
);

    logic rs_ex_match;
    logic rt_ex_match;

    function automatic logic hits(
        input id_pkg::rf_write_t             w,
        input logic [id_pkg::reg_addr_w-1:0] addr
    );
        return w.we && w.waddr != '0 && w.waddr == addr;
    endfunction

    // ex result is newer than mem
    function automatic logic [id_pkg::xlen-1:0] pick(
        input logic [id_pkg::reg_addr_w-1:0] addr,
        input logic [id_pkg::xlen-1:0]       rf_data
    );
        if (hits(ex_fwd, addr)) begin
            return ex_fwd.wdata;
        end
        if (hits(mem_fwd, addr)) begin
            return mem_fwd.wdata;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_data = pick(rs, rf_rs_data);
        rt_data = pick(rt, rf_rt_data);
    end

    // load in ex, data not ready until mem
    assign rs_ex_match    = ex_fwd.waddr != '0 && ex_fwd.waddr == rs;
    assign rt_ex_match    = ex_fwd.waddr != '0 && ex_fwd.waddr == rt;
    assign stall_for_load = ex_ram_read && (rs_ex_match || rt_ex_match);

endmodule

/* regfile.sv */
module regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::rf_write_t             wb
);

    // register zero is not stored
    logic [id_pkg::xlen-1:0] regs [31:1];

    function automatic logic [id_pkg::xlen-1:0] read_port(
        input logic [id_pkg::reg_addr_w-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        // write-back in the same cycle wins
        if (wb.we && wb.waddr == addr) begin
            return wb.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage \
    -f id_stage.f --Mdir obj_dir -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_id_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* tb_id_stage.sv */
module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_loop      = 600;
    localparam int n_issue     = n_loop + 31;
    localparam int cycle_limit = 8 * n_issue + 200;

    localparam logic [5:0] reg_fn [14] = '{
        6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26,
        6'h27, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07
    };
    localparam logic [5:0] imm_op [9] = '{
        6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b
    };

    typedef struct packed {
        id_pkg::id_ex_t id_ex;
        id_pkg::br_t    br;
        logic           sfl;
        logic           ctl_chk;
    } expect_t;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              ex_ram_read;
    id_pkg::stall_t    stall;
    id_pkg::if_id_t    if_id;
    id_pkg::rf_write_t ex_fwd;
    id_pkg::rf_write_t mem_fwd;
    id_pkg::rf_write_t wb;
    id_pkg::id_ex_t    id_ex;
    id_pkg::br_t       br;
    logic              stall_for_load;

    integer      seed;
    int          errors;
    int          cycles;
    logic [31:0] shadow [32];
    logic        m_valid;
    logic [31:0] m_pc;
    logic [31:0] m_inst;

    id_stage DUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // shadow register file follows write-back
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb.we && wb.waddr != 5'd0) begin
            shadow[wb.waddr] <= wb.wdata;
        end
    end

    // expected IF/ID entry
    always @(posedge clk) begin
        if (rst || flush || (stall.if_stop && !stall.id_stop)) begin
            m_valid <= 1'b0;
            m_pc    <= '0;
            m_inst  <= '0;
        end else if (!stall.if_stop) begin
            m_valid <= if_id.valid;
            m_pc    <= if_id.pc;
            m_inst  <= if_id.inst;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the test did not end within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] rf_read(input logic [4:0] a);
        if (a == 5'd0) begin
            return '0;
        end
        if (wb.we && wb.waddr == a) begin
            return wb.wdata;
        end
        return shadow[a];
    endfunction

    function automatic logic [31:0] operand(input logic [4:0] a);
        if (ex_fwd.we && ex_fwd.waddr != 5'd0 && ex_fwd.waddr == a) begin
            return ex_fwd.wdata;
        end
        if (mem_fwd.we && mem_fwd.waddr != 5'd0 && mem_fwd.waddr == a) begin
            return mem_fwd.wdata;
        end
        return rf_read(a);
    endfunction

    function automatic expect_t with_imm(
        input expect_t        e,
        input id_pkg::alu_op_e op,
        input id_pkg::src2_e   s2,
        input logic [4:0]      rt
    );
        e.id_ex.rf_we    = 1'b1;
        e.id_ex.rf_waddr = rt;
        e.id_ex.alu_op   = op;
        e.id_ex.src2     = s2;
        return e;
    endfunction

    // expected stage outputs for the held entry and the current side inputs
    function automatic expect_t reference(
        input logic        valid,
        input logic [31:0] pc,
        input logic [31:0] inst
    );
        expect_t          e;
        id_pkg::br_kind_e kind;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [4:0]       rd;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      pc4;
        logic             known;
        e      = '0;
        kind   = id_pkg::br_none;
        known  = 1'b1;
        rs     = inst[25:21];
        rt     = inst[20:16];
        rd     = inst[15:11];
        a      = operand(rs);
        b      = operand(rt);
        pc4    = pc + 32'd4;
        e.ctl_chk        = 1'b1;
        e.id_ex.valid    = valid;
        e.id_ex.pc       = pc;
        e.id_ex.inst     = inst;
        e.id_ex.alu_op   = id_pkg::alu_add;
        e.id_ex.src1     = id_pkg::src1_rs;
        e.id_ex.src2     = id_pkg::src2_rt;
        e.id_ex.rs_data  = a;
        e.id_ex.rt_data  = b;
        case (inst[31:26])
            6'h00: begin
                e.id_ex.rf_we    = 1'b1;
                e.id_ex.rf_waddr = rd;
                case (inst[5:0])
                    6'h21: e.id_ex.alu_op = id_pkg::alu_add;
                    6'h23: e.id_ex.alu_op = id_pkg::alu_sub;
                    6'h2a: e.id_ex.alu_op = id_pkg::alu_slt;
                    6'h2b: e.id_ex.alu_op = id_pkg::alu_sltu;
                    6'h24: e.id_ex.alu_op = id_pkg::alu_and;
                    6'h25: e.id_ex.alu_op = id_pkg::alu_or;
                    6'h26: e.id_ex.alu_op = id_pkg::alu_xor;
                    6'h27: e.id_ex.alu_op = id_pkg::alu_nor;
                    6'h04: e.id_ex.alu_op = id_pkg::alu_sll;
                    6'h06: e.id_ex.alu_op = id_pkg::alu_srl;
                    6'h07: e.id_ex.alu_op = id_pkg::alu_sra;
                    6'h00, 6'h02, 6'h03: begin
                        e.id_ex.src1 = id_pkg::src1_sa;
                        if (inst[5:0] == 6'h00) begin
                            e.id_ex.alu_op = id_pkg::alu_sll;
                        end else if (inst[5:0] == 6'h02) begin
                            e.id_ex.alu_op = id_pkg::alu_srl;
                        end else begin
                            e.id_ex.alu_op = id_pkg::alu_sra;
                        end
                    end
                    6'h08: begin
                        e.id_ex.rf_we = 1'b0;
                        e.ctl_chk     = 1'b0;
                        kind          = id_pkg::br_jr;
                    end
                    6'h09: begin
                        e.id_ex.src1     = id_pkg::src1_pc;
                        e.id_ex.src2     = id_pkg::src2_eight;
                        e.id_ex.rf_waddr = 5'd31;
                        kind             = id_pkg::br_jalr;
                    end
                    default: known = 1'b0;
                endcase
            end
            6'h01: begin
                e.ctl_chk = 1'b0;
                if (rt == 5'd0) begin
                    kind = id_pkg::br_bltz;
                end else if (rt == 5'd1) begin
                    kind = id_pkg::br_bgez;
                end else begin
                    known = 1'b0;
                end
            end
            6'h02: kind = id_pkg::br_j;
            6'h03: begin
                e.id_ex.src1     = id_pkg::src1_pc;
                e.id_ex.src2     = id_pkg::src2_eight;
                e.id_ex.rf_we    = 1'b1;
                e.id_ex.rf_waddr = 5'd31;
                kind             = id_pkg::br_jal;
            end
            6'h04: kind = id_pkg::br_beq;
            6'h05: kind = id_pkg::br_bne;
            6'h06: kind = id_pkg::br_blez;
            6'h07: kind = id_pkg::br_bgtz;
            6'h09: e = with_imm(e, id_pkg::alu_add, id_pkg::src2_simm, rt);
            6'h0a: e = with_imm(e, id_pkg::alu_slt, id_pkg::src2_simm, rt);
            6'h0b: e = with_imm(e, id_pkg::alu_sltu, id_pkg::src2_simm, rt);
            6'h0c: e = with_imm(e, id_pkg::alu_and, id_pkg::src2_zimm, rt);
            6'h0d: e = with_imm(e, id_pkg::alu_or, id_pkg::src2_zimm, rt);
            6'h0e: e = with_imm(e, id_pkg::alu_xor, id_pkg::src2_zimm, rt);
            6'h0f: e = with_imm(e, id_pkg::alu_lui, id_pkg::src2_simm, rt);
            6'h23: begin
                e = with_imm(e, id_pkg::alu_add, id_pkg::src2_simm, rt);
                e.id_ex.mem_read = 1'b1;
            end
            6'h2b: begin
                e.id_ex.src2      = id_pkg::src2_simm;
                e.id_ex.mem_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // the remaining branch kinds carry no ALU work
        if (kind inside {id_pkg::br_j, id_pkg::br_beq, id_pkg::br_bne,
                         id_pkg::br_blez, id_pkg::br_bgtz}) begin
            e.ctl_chk = 1'b0;
        end
        if (!valid || !known) begin
            e.id_ex.rf_we     = 1'b0;
            e.id_ex.rf_waddr  = '0;
            e.id_ex.mem_read  = 1'b0;
            e.id_ex.mem_write = 1'b0;
            e.ctl_chk         = 1'b0;
            kind              = id_pkg::br_none;
        end
        e.br.target = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
        case (kind)
            id_pkg::br_beq:  e.br.taken = (a == b);
            id_pkg::br_bne:  e.br.taken = (a != b);
            id_pkg::br_bgez: e.br.taken = ($signed(a) >= 0);
            id_pkg::br_bltz: e.br.taken = ($signed(a) < 0);
            id_pkg::br_bgtz: e.br.taken = ($signed(a) > 0);
            id_pkg::br_blez: e.br.taken = ($signed(a) <= 0);
            id_pkg::br_j, id_pkg::br_jal: begin
                e.br.taken  = 1'b1;
                e.br.target = {pc4[31:28], inst[25:0], 2'b00};
            end
            id_pkg::br_jr, id_pkg::br_jalr: begin
                e.br.taken  = 1'b1;
                e.br.target = a;
            end
            default: begin
                e.br.taken  = 1'b0;
                e.br.target = '0;
            end
        endcase
        e.sfl = ex_ram_read && ex_fwd.waddr != 5'd0 &&
                (ex_fwd.waddr == rs || ex_fwd.waddr == rt);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            e = reference(m_valid, m_pc, m_inst);
            check_value("id_ex.valid", 32'(e.id_ex.valid), 32'(id_ex.valid));
            check_value("id_ex.pc", e.id_ex.pc, id_ex.pc);
            check_value("id_ex.inst", e.id_ex.inst, id_ex.inst);
            check_value("id_ex.rf_we", 32'(e.id_ex.rf_we), 32'(id_ex.rf_we));
            check_value("id_ex.mem_read", 32'(e.id_ex.mem_read), 32'(id_ex.mem_read));
            check_value("id_ex.mem_write", 32'(e.id_ex.mem_write), 32'(id_ex.mem_write));
            check_value("id_ex.rs_data", e.id_ex.rs_data, id_ex.rs_data);
            check_value("id_ex.rt_data", e.id_ex.rt_data, id_ex.rt_data);
            check_value("stall_for_load", 32'(e.sfl), 32'(stall_for_load));
            check_value("br.taken", 32'(e.br.taken), 32'(br.taken));
            check_value("br.target", e.br.target, br.target);
            if (e.id_ex.rf_we) begin
                check_value("id_ex.rf_waddr", 32'(e.id_ex.rf_waddr), 32'(id_ex.rf_waddr));
            end
            if (e.ctl_chk) begin
                check_value("id_ex.alu_op", 32'(e.id_ex.alu_op), 32'(id_ex.alu_op));
                check_value("id_ex.src1", 32'(e.id_ex.src1), 32'(id_ex.src1));
                check_value("id_ex.src2", 32'(e.id_ex.src2), 32'(id_ex.src2));
            end
        end
    end

    // small register numbers most of the time so that forwarding hits
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[3:0] < 4'd12) ? {2'b00, r[6:4]} : r[12:8];
    endfunction

    function automatic logic [31:0] pick_data();
        logic [31:0] r;
        r = $random(seed);
        case (r[3:0])
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'h7fff_ffff;
            4'd3:    return 32'hffff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic id_pkg::rf_write_t make_write();
        id_pkg::rf_write_t w;
        logic [31:0]       r;
        r       = $random(seed);
        w.we    = r[0];
        w.waddr = pick_reg();
        w.wdata = pick_data();
        return w;
    endfunction

    function automatic logic [31:0] make_inst(input int cls, input int n);
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  rs;
        r   = $random(seed);
        rs  = pick_reg();
        imm = (r[1:0] == 2'd0) ? 16'h8000 : (r[1:0] == 2'd1) ? 16'h7fff : r[31:16];
        case (cls)
            0: return {6'h00, rs, pick_reg(), pick_reg(), r[10:6], reg_fn[r[7:4] % 14]};
            1: return {imm_op[r[11:8] % 9], rs, pick_reg(), imm};
            2: begin
                case (n % 10)
                    0: return {6'h04, rs, pick_reg(), imm};
                    1: return {6'h05, rs, pick_reg(), imm};
                    2: return {6'h01, rs, 5'd1, imm};
                    3: return {6'h01, rs, 5'd0, imm};
                    4: return {6'h07, rs, 5'd0, imm};
                    5: return {6'h06, rs, 5'd0, imm};
                    6: return {6'h02, r[25:0]};
                    7: return {6'h03, r[25:0]};
                    8: return {6'h00, rs, 15'd0, 6'h08};
                    default: return {6'h00, rs, 5'd0, 5'd31, 5'd0, 6'h09};
                endcase
            end
            default: return $random(seed);
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        expect_t     e;
        seed        = 32'h9968_0077;
        errors      = 0;
        cycles      = 0;
        rst         = 1'b1;
        flush       = 1'b0;
        stall       = '0;
        if_id       = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        wb          = '0;
        ex_ram_read = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        // fill the file; the decoded read of rs meets its own write-back
        for (int k = 1; k < 32; k++) begin
            wb.we       = 1'b1;
            wb.waddr    = 5'(k);
            wb.wdata    = pick_data();
            if_id.valid = 1'b1;
            if_id.pc    = 32'(k) << 2;
            if_id.inst  = {6'h00, 5'(k + 1), 5'(k), 5'(k), 5'd0, 6'h21};
            @(posedge clk);
            #1;
        end

        for (int i = 0; i < n_loop; i++) begin
            r           = $random(seed);
            if_id.valid = (r[3:0] != 4'd0);
            if_id.pc    = {r[31:2], 2'b00};
            if_id.inst  = make_inst(i % 4, i / 4);
            ex_fwd      = make_write();
            mem_fwd     = make_write();
            wb          = make_write();
            r           = $random(seed);
            ex_ram_read = r[0];
            flush       = (r[7:4] == 4'd0);
            // controller answers a load-use hazard with both stops
            e = reference(m_valid, m_pc, m_inst);
            if (e.sfl) begin
                stall = '{if_stop: 1'b1, id_stop: 1'b1};
            end else begin
                case (r[11:9])
                    3'd0:    stall = '{if_stop: 1'b1, id_stop: 1'b0};
                    3'd1:    stall = '{if_stop: 1'b0, id_stop: 1'b1};
                    3'd2:    stall = '{if_stop: 1'b1, id_stop: 1'b1};
                    default: stall = '0;
                endcase
            end
            @(posedge clk);
            #1;
        end

        stall = '0;
        flush = 1'b0;
        @(posedge clk);
        #1;
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb_id_stage_assertions.sv */
module tb_id_stage_assertions (
    input logic              clk,
    input logic              rst,
    input logic              ex_ram_read,
    input logic              stall_for_load,
    input id_pkg::id_ex_t    id_ex,
    input id_pkg::br_t       br
);

    timeunit 1ns;
    timeprecision 1ps;

    // reset clears the IF/ID entry
    valid_low_after_reset: assert property (
        @(posedge clk) rst |=> !id_ex.valid
    ) else $error("id_ex.valid high in the cycle after reset");

    taken_needs_valid: assert property (
        @(posedge clk) disable iff (rst) br.taken |-> id_ex.valid
    ) else $error("br.taken high without a valid instruction");

    load_stall_needs_load: assert property (
        @(posedge clk) disable iff (rst) stall_for_load |-> ex_ram_read
    ) else $error("stall_for_load high without a load in EX");

endmodule

bind id_stage tb_id_stage_assertions u_assertions (.*);
